/* vlog.f */
alu_pkg.sv
apb_map_pkg.sv
ripple_adder.sv
alu_core.sv
alu_apb_regs.sv
alu_top.sv
tb_clk_gen.sv
tb_alu_top.sv

/* Bender.yml */
package:
  name: alu_apb

sources:
  - files:
      - alu_pkg.sv
      - apb_map_pkg.sv
      - ripple_adder.sv
      - alu_core.sv
      - alu_apb_regs.sv
      - alu_top.sv

  - target: test
    files:
      - tb_clk_gen.sv
      - tb_alu_top.sv

/* tb_alu_top.sv */
`timescale 1ns/1ps

module tb_alu_top
   import alu_pkg::*;
   import apb_map_pkg::*;
();

   localparam int xfer_timeout_lp  = 16;
   localparam int drain_timeout_lp = 100;
   localparam int random_pairs_lp  = 200;

   typedef struct packed {
      alu_flags_t flags;
      alu_word_t  result;
   } alu_expect_t;

   logic      clk;
   logic      rst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   // Values waiting for the compare process
   apb_data_t act_q[$];
   apb_data_t exp_q[$];
   string     what_q[$];
   int        checks_done;
   integer    seed;

   tb_clk_gen clk_gen0 (
      .clk (clk)
   );

   alu_top dut0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_eq(input string what, input apb_data_t actual, input apb_data_t expected);
      if (actual !== expected) begin
         stop_with_failure($sformatf("ERR %0t: %s got %08h expected %08h",
                                     $time, what, actual, expected));
      end
   endtask

   task automatic expect_value(input string what, input apb_data_t actual,
                               input apb_data_t expected);
      what_q.push_back(what);
      act_q.push_back(actual);
      exp_q.push_back(expected);
   endtask

   // Expected result and flags straight from the ALU rules
   function automatic alu_expect_t alu_model(input alu_word_t a, input alu_word_t b,
                                             input alu_op_e op);
      alu_expect_t exp;
      alu_word_t   b_in;
      logic [32:0] wide;
      logic [31:0] low;
      logic        cin;
      logic        arith;
      cin   = (op == op_sub);
      b_in  = cin ? ~b : b;
      wide  = {1'b0, a} + {1'b0, b_in} + {32'd0, cin};
      // Bit 31 of this sum is the carry into the sign bit
      low   = {1'b0, a[30:0]} + {1'b0, b_in[30:0]} + {31'd0, cin};
      arith = (op == op_add) || (op == op_sub);
      exp   = '0;
      case (op)
         op_add, op_sub: exp.result = wide[31:0];
         op_xor:         exp.result = a ^ b;
         op_slt:         exp.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         op_and:         exp.result = a & b;
         op_nand:        exp.result = ~(a & b);
         op_nor:         exp.result = ~(a | b);
         default:        exp.result = a | b;
      endcase
      exp.flags[flag_zero_lp] = (exp.result == 32'd0);
      if (arith) begin
         exp.flags[flag_carry_lp]    = wide[32];
         exp.flags[flag_overflow_lp] = low[31] ^ wide[32];
      end
      return exp;
   endfunction

   // One APB transfer, setup then access, sampled mid-cycle
   task automatic bus_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                               output apb_data_t rdata, output logic err);
      int waits;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      waits = 0;
      @(negedge clk);
      while (pready !== 1'b1) begin
         waits++;
         if (waits > xfer_timeout_lp) begin
            stop_with_failure($sformatf("Timeout waiting for pready at address %02h", addr));
         end
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic write_reg(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
      apb_data_t unused;
      logic      err;
      bus_transfer(1'b1, addr, data, unused, err);
      expect_value($sformatf("pslverr on write to %02h", addr), {31'd0, err}, {31'd0, exp_err});
   endtask

   task automatic read_reg(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
      logic err;
      bus_transfer(1'b0, addr, 32'd0, data, err);
      expect_value($sformatf("pslverr on read of %02h", addr), {31'd0, err}, {31'd0, exp_err});
   endtask

   task automatic load_operands(input alu_word_t a, input alu_word_t b);
      write_reg(reg_opa_lp, a, 1'b0);
      write_reg(reg_opb_lp, b, 1'b0);
   endtask

   task automatic launch_and_check(input alu_word_t a, input alu_word_t b, input alu_op_e op);
      apb_data_t   res;
      apb_data_t   flg;
      alu_expect_t exp;
      write_reg(reg_cmd_lp, {29'd0, op}, 1'b0);
      read_reg(reg_result_lp, 1'b0, res);
      read_reg(reg_flags_lp, 1'b0, flg);
      exp = alu_model(a, b, op);
      expect_value($sformatf("%s result a=%08h b=%08h", op.name(), a, b), res, exp.result);
      expect_value($sformatf("%s flags a=%08h b=%08h", op.name(), a, b), flg,
                   {29'd0, exp.flags});
   endtask

   task automatic run_op(input alu_word_t a, input alu_word_t b, input alu_op_e op);
      load_operands(a, b);
      launch_and_check(a, b, op);
   endtask

   // Compare process
   initial begin
      apb_data_t act;
      apb_data_t exp;
      string     what;
      checks_done = 0;
      forever begin
         @(posedge clk);
         while (act_q.size() != 0) begin
            what = what_q.pop_front();
            act  = act_q.pop_front();
            exp  = exp_q.pop_front();
            check_eq(what, act, exp);
            checks_done++;
         end
      end
   end

   initial begin
      apb_data_t   rd;
      alu_expect_t exp_v;
      apb_data_t   want[5];
      apb_addr_t   regs[5];
      alu_word_t   a;
      alu_word_t   b;
      int          waits;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      rst_n   = 1'b0;
      seed    = 32'h44fe;
      regs    = '{reg_opa_lp, reg_opb_lp, reg_cmd_lp, reg_result_lp, reg_flags_lp};
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // Reset state
      for (int i = 0; i < 5; i++) begin
         read_reg(regs[i], 1'b0, rd);
         expect_value($sformatf("reset value at %02h", regs[i]), rd, 32'd0);
      end

      // Register access and CMD masking
      write_reg(reg_opa_lp, 32'hA5A5_1234, 1'b0);
      write_reg(reg_opb_lp, 32'h0F0F_F0F0, 1'b0);
      write_reg(reg_cmd_lp, 32'hFFFF_FFFE, 1'b0);
      read_reg(reg_opa_lp, 1'b0, rd);
      expect_value("OPA readback", rd, 32'hA5A5_1234);
      read_reg(reg_opb_lp, 1'b0, rd);
      expect_value("OPB readback", rd, 32'h0F0F_F0F0);
      read_reg(reg_cmd_lp, 1'b0, rd);
      expect_value("CMD readback", rd, 32'd6);
      exp_v = alu_model(32'hA5A5_1234, 32'h0F0F_F0F0, op_nor);
      read_reg(reg_result_lp, 1'b0, rd);
      expect_value("nor from CMD write", rd, exp_v.result);
      write_reg(reg_opa_lp, 32'h0000_0001, 1'b0);
      read_reg(reg_result_lp, 1'b0, rd);
      expect_value("RESULT after OPA write", rd, exp_v.result);

      // Arithmetic corners
      for (int k = 0; k < 2; k++) begin
         run_op(32'h7FFF_FFFF, 32'h0000_0001, alu_op_e'(k));
         run_op(32'h8000_0000, 32'h0000_0001, alu_op_e'(k));
         run_op(32'hFFFF_FFFF, 32'h0000_0001, alu_op_e'(k));
         run_op(32'h1234_5678, 32'h1234_5678, alu_op_e'(k));
      end

      // slt with mixed signs
      run_op(32'hFFFF_FFFF, 32'h0000_0001, op_slt);
      run_op(32'h0000_0001, 32'hFFFF_FFFF, op_slt);
      run_op(32'h8000_0000, 32'h7FFF_FFFF, op_slt);
      run_op(32'h7FFF_FFFF, 32'h8000_0000, op_slt);
      run_op(32'h0000_0005, 32'h0000_0005, op_slt);

      // Bitwise ops on patterns
      for (int k = 2; k < 8; k++) begin
         if (k != 3) begin
            run_op(32'hF0F0_F0F0, 32'hFF00_FF00, alu_op_e'(k));
            run_op(32'hAAAA_AAAA, 32'h5555_5555, alu_op_e'(k));
            run_op(32'h0000_0000, 32'h0000_0000, alu_op_e'(k));
            run_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, alu_op_e'(k));
         end
      end

      // Random sweep
      for (int n = 0; n < random_pairs_lp; n++) begin
         a = $random(seed);
         b = $random(seed);
         load_operands(a, b);
         for (int k = 0; k < 8; k++) begin
            launch_and_check(a, b, alu_op_e'(k));
         end
      end

      // Slave errors leave registers alone
      exp_v = alu_model(a, b, op_or);
      want  = '{a, b, 32'd7, exp_v.result, {29'd0, exp_v.flags}};
      write_reg(reg_result_lp, 32'hDEAD_BEEF, 1'b1);
      write_reg(reg_flags_lp, 32'h0000_0007, 1'b1);
      write_reg(8'h14, 32'h1234_5678, 1'b1);
      write_reg(8'h03, 32'h8765_4321, 1'b1);
      read_reg(8'h40, 1'b1, rd);
      expect_value("unmapped read data", rd, 32'd0);
      for (int i = 0; i < 5; i++) begin
         read_reg(regs[i], 1'b0, rd);
         expect_value($sformatf("register %02h after failed writes", regs[i]), rd, want[i]);
      end

      waits = 0;
      while (act_q.size() != 0) begin
         @(posedge clk);
         waits++;
         if (waits > drain_timeout_lp) begin
            stop_with_failure("Compare queue did not drain before the end of the run");
         end
      end
      @(posedge clk);
      $display("%0d values compared", checks_done);
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk
);

   // 20 ns period
   localparam realtime half_period_lp = 10.0;

   initial begin
      clk = 1'b0;
   end

   always begin
      #half_period_lp;
      clk = ~clk;
   end

endmodule

/* alu_top.sv */
`timescale 1ns/1ps

module alu_top
   import alu_pkg::*;
   import apb_map_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr
);

   // Register block to core
   alu_word_t  opa;
   alu_word_t  opb;
   alu_op_e    op;

   // Core back to register block
   alu_word_t  result;
   alu_flags_t flags;

   alu_apb_regs regs0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .opa     (opa),
      .opb     (opb),
      .op      (op),
      .result  (result),
      .flags   (flags)
   );

   alu_core core0 (
      .opa    (opa),
      .opb    (opb),
      .op     (op),
      .result (result),
      .flags  (flags)
   );

endmodule

/* alu_apb_regs.sv */
`timescale 1ns/1ps

module alu_apb_regs
   import alu_pkg::*;
   import apb_map_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   // APB slave
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_addr_t  paddr,
   input  apb_data_t  pwdata,
   output apb_data_t  prdata,
   output logic       pready,
   output logic       pslverr,

   // ALU core side
   output alu_word_t  opa,
   output alu_word_t  opb,
   output alu_op_e    op,
   input  alu_word_t  result,
   input  alu_flags_t flags
);

   logic       access;
   logic       sel_opa;
   logic       sel_opb;
   logic       sel_cmd;
   logic       sel_result;
   logic       sel_flags;
   logic       addr_hit;
   logic       read_only;
   logic       wr_ok;
   logic       launch_q;
   alu_word_t  result_q;
   alu_flags_t flags_q;

   // Access cycle of a transfer
   assign access = psel & penable;

   assign sel_opa    = (paddr == reg_opa_lp);
   assign sel_opb    = (paddr == reg_opb_lp);
   assign sel_cmd    = (paddr == reg_cmd_lp);
   assign sel_result = (paddr == reg_result_lp);
   assign sel_flags  = (paddr == reg_flags_lp);

   assign addr_hit  = sel_opa | sel_opb | sel_cmd | sel_result | sel_flags;
   assign read_only = sel_result | sel_flags;

   // Unmapped addresses and writes to status registers fail
   assign pslverr = access & (~addr_hit | (pwrite & read_only));
   assign wr_ok   = access & pwrite & addr_hit & ~read_only;

   // Zero wait states
   assign pready = 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         opa <= '0;
         opb <= '0;
         op  <= op_add;
      end else if (wr_ok) begin
         if (sel_opa) begin
            opa <= pwdata;
         end
         if (sel_opb) begin
            opb <= pwdata;
         end
         if (sel_cmd) begin
            op <= alu_op_e'(pwdata[alu_op_width_lp-1:0]);
         end
      end
   end

   // Pulse for one cycle after the CMD write lands
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         launch_q <= 1'b0;
      end else begin
         launch_q <= wr_ok & sel_cmd;
      end
   end

   // Core output is settled for the new command by now
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result_q <= '0;
         flags_q  <= '0;
      end else if (launch_q) begin
         result_q <= result;
         flags_q  <= flags;
      end
   end

   always_comb begin
      case (paddr)
         reg_opa_lp:    prdata = opa;
         reg_opb_lp:    prdata = opb;
         reg_cmd_lp:    prdata = {{(apb_data_width_lp - alu_op_width_lp){1'b0}}, op};
         reg_result_lp: prdata = result_q;
         reg_flags_lp:  prdata = {{(apb_data_width_lp - alu_flags_width_lp){1'b0}}, flags_q};
         default:       prdata = '0;
      endcase
   end

endmodule

/* alu_core.sv */
`timescale 1ns/1ps

module alu_core
   import alu_pkg::*;
(
   input  alu_word_t  opa,
   input  alu_word_t  opb,
   input  alu_op_e    op,
   output alu_word_t  result,
   output alu_flags_t flags
);

   logic      sub_mode;
   logic      arith_op;
   alu_word_t add_b;
   alu_word_t sum;
   logic      cout;
   logic      ovf;
   logic      slt_bit;

   // Subtract and slt both run A + ~B + 1 through the adder
   assign sub_mode = (op == op_sub) || (op == op_slt);
   assign arith_op = (op == op_add) || (op == op_sub);
   assign add_b    = sub_mode ? ~opb : opb;

   ripple_adder adder0 (
      .a    (opa),
      .b    (add_b),
      .cin  (sub_mode),
      .sum  (sum),
      .cout (cout),
      .ovf  (ovf)
   );

   // Signed less-than from sign of the difference corrected by overflow
   assign slt_bit = sum[alu_width_lp - 1] ^ ovf;

   always_comb begin
      case (op)
         op_add,
         op_sub:  result = sum;
         op_xor:  result = opa ^ opb;
         op_slt:  result = {{(alu_width_lp - 1){1'b0}}, slt_bit};
         op_and:  result = opa & opb;
         op_nand: result = ~(opa & opb);
         op_nor:  result = ~(opa | opb);
         op_or:   result = opa | opb;
         default: result = '0;
      endcase
   end

   // Carry and overflow only mean something for add and sub
   always_comb begin
      flags                   = '0;
      flags[flag_zero_lp]     = (result == '0);
      flags[flag_carry_lp]    = arith_op & cout;
      flags[flag_overflow_lp] = arith_op & ovf;
   end

endmodule

/* ripple_adder.sv */
`timescale 1ns/1ps

module ripple_adder
   import alu_pkg::*;
(
   input  alu_word_t a,
   input  alu_word_t b,
   input  logic      cin,
   output alu_word_t sum,
   output logic      cout,
   output logic      ovf
);

   // carry[i] is the carry into bit i
   logic [alu_width_lp:0] carry;

   assign carry[0] = cin;

   for (genvar i = 0; i < alu_width_lp; i++) begin : g_bit
      logic half;

      // Full adder cell
      assign half         = a[i] ^ b[i];
      assign sum[i]       = half ^ carry[i];
      assign carry[i + 1] = (a[i] & b[i]) | (half & carry[i]);
   end

   assign cout = carry[alu_width_lp];

   // Signed overflow when the carries into and out of the sign bit differ
   assign ovf = carry[alu_width_lp - 1] ^ carry[alu_width_lp];

endmodule

/* apb_map_pkg.sv */
package apb_map_pkg;

   localparam int apb_addr_width_lp = 8;
   localparam int apb_data_width_lp = 32;

   typedef logic [apb_addr_width_lp-1:0] apb_addr_t;
   typedef logic [apb_data_width_lp-1:0] apb_data_t;

   // Register byte offsets
   localparam apb_addr_t reg_opa_lp    = 8'h00;
   localparam apb_addr_t reg_opb_lp    = 8'h04;
   localparam apb_addr_t reg_cmd_lp    = 8'h08;

   // Read-only status
   localparam apb_addr_t reg_result_lp = 8'h0C;
   localparam apb_addr_t reg_flags_lp  = 8'h10;

endpackage

/* alu_pkg.sv */
package alu_pkg;

   // Datapath widths
   localparam int alu_width_lp       = 32;
   localparam int alu_op_width_lp    = 3;
   localparam int alu_flags_width_lp = 3;

   // Bit positions inside the flags word
   localparam int flag_zero_lp     = 0;
   localparam int flag_carry_lp    = 1;
   localparam int flag_overflow_lp = 2;

   typedef logic [alu_width_lp-1:0]       alu_word_t;
   typedef logic [alu_flags_width_lp-1:0] alu_flags_t;

   // Command encoding as seen by software in CMD
   typedef enum logic [alu_op_width_lp-1:0] {
      op_add  = 3'd0,
      op_sub  = 3'd1,
      op_xor  = 3'd2,
      op_slt  = 3'd3,
      op_and  = 3'd4,
      op_nand = 3'd5,
      op_nor  = 3'd6,
      op_or   = 3'd7
   } alu_op_e;

endpackage
